// ==== programVectors.txt ====
# test <name>, prog <instruction words>, data <addr> <value>, store <addr> <value> in order, run
# all numbers hex, addresses are word indexes
test aluForwarding
prog 0820000C 08410005 04620800 04830801 04A41802 04C50803
prog 04E61004 05072005 05283806 05494007 05611801 058B0807
prog 10400022 10600023 10800024 10A00025 10C00026 10E00027
prog 11000028 11200029 1140002A 1160002B 1180002C 20000000
store 22 00000011 23 0000001D 24 00000011 25 00000011
store 26 0000001D 27 0000000C 28 00180000 29 00000180
store 2A 00000001 2B FFFFFFEF 2C 00000001
run

test loadUse
prog 0C200010 04410800 10400030 0C61FF11 10600031 0C800031
prog 04A41000 10A40010 20000000
data 10 00000100 11 00000023
store 30 00000200 31 00000023 33 00000223
run

test branchJump
prog 08200007 08400007 14220002 10200040 10400041 18220001
prog 10200042 1C00000A 10400043 10200044 08600003 18610001
prog 10600045 10600046 20000000 10200047 10200048
store 42 00000007 46 00000003
run

test waitLoop
prog 08200005 08400000 04420800 10410050 0821FFFF 1820FFFC 20000000
store 55 00000005 54 00000009 53 0000000C 52 0000000E 51 0000000F
run

test zeroReg
prog 08000009 10000060 08200004 04010800 04400800 10400061
prog 0C000062 10000063 20000000
data 62 00000055
store 60 00000000 61 00000004 63 00000000
run

// ==== filelist.f ====
cpuPkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardUnit.sv
pipelineCpu.sv
tbMemory.sv
tbCpu.sv

// ==== Makefile ====
# Verilator build and run of the pipelined CPU testbench

VERILATOR ?= verilator
TOP ?= tbCpu
FLAGS ?= --binary --timing --assert -Wno-fatal
OBJDIR ?= obj_dir
FILELIST ?= filelist.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^RESULT: PASS$$"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== tbCpu.sv ====
// Testbench that runs each program from the vector file on the CPU and checks its stores
module tbCpu;

	localparam string vectorFile = "programVectors.txt";
	localparam int cyclesPerTest = 400;
	localparam int clockPeriod = 10;
	localparam int settleCycles = 20;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [31:0] instrData;
	logic instrReady;
	logic [31:0] readData;
	logic dataReady;
	logic [31:0] instrAddr;
	logic instrValid;
	logic [31:0] dataAddr;
	logic [31:0] writeData;
	logic dataWrite;
	logic dataValid;
	logic halt;

	int testCount = 0;
	int passCount = 0;
	int failCount = 0;
	bit counted = 1'b0;
	logic [31:0] expAddrs [$];
	logic [31:0] expValues [$];

	pipelineCpu u_pipelineCpu (.*);

	tbMemory u_memory (.*);

	always #(clockPeriod / 2) clk = ~clk;

	initial begin
		wait (counted);
		#(testCount * cyclesPerTest * clockPeriod);
		$display("Timeout: halt not reached within %0d cycles", testCount * cyclesPerTest);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic countTests(output int count);
		int fd;
		string tok;
		string rest;
		count = 0;
		fd = $fopen(vectorFile, "r");
		if (fd != 0) begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#")
					void'($fgets(rest, fd));
				else if (tok == "test")
					count++;
			end
			$fclose(fd);
		end
	endtask

	task automatic checkStores(input string name, input bit haltDropped);
		int errors;
		int shown;
		int i;
		errors = 0;
		if (haltDropped) begin
			$display("%s: halt went low again before reset", name);
			errors++;
		end
		if (u_memory.storeAddrs.size() != expAddrs.size()) begin
			$display("%s: expected %0d stores but the CPU made %0d", name, expAddrs.size(),
				u_memory.storeAddrs.size());
			errors++;
		end
		shown = (u_memory.storeAddrs.size() < expAddrs.size()) ?
			u_memory.storeAddrs.size() : expAddrs.size();
		for (i = 0; i < shown; i++) begin
			if (u_memory.storeAddrs[i] !== expAddrs[i] ||
					u_memory.storeValues[i] !== expValues[i]) begin
				$display("Mismatch in %s store %0d: expected [%h] %h, actual [%h] %h", name, i,
					expAddrs[i], expValues[i], u_memory.storeAddrs[i], u_memory.storeValues[i]);
				errors++;
			end
		end
		if (errors == 0) begin
			passCount++;
			$display("%s passed with %0d stores", name, expAddrs.size());
		end else begin
			failCount++;
			$display("%s failed with %0d errors", name, errors);
		end
	endtask

	task automatic runTest(input string name);
		bit haltDropped;
		haltDropped = 1'b0;
		@(posedge clk);
		#1;
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		while (!halt) begin
			@(posedge clk);
			#1;
		end
		// Younger instructions must stay quiet after halt
		repeat (settleCycles) begin
			@(posedge clk);
			#1;
			if (!halt)
				haltDropped = 1'b1;
		end
		checkStores(name, haltDropped);
	endtask

	initial begin
		int fd;
		int progLen;
		string tok;
		string mode;
		string name;
		string rest;
		logic [31:0] word;
		logic [31:0] value;
		progLen = 0;
		mode = "";
		name = "";
		countTests(testCount);
		counted = testCount > 0;
		fd = $fopen(vectorFile, "r");
		if (fd == 0) begin
			$display("Could not open %s", vectorFile);
			failCount++;
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					void'($fgets(rest, fd));
				end else if (tok == "test") begin
					void'($fscanf(fd, "%s", name));
					u_memory.clearMemories();
					expAddrs.delete();
					expValues.delete();
					progLen = 0;
				end else if (tok == "prog" || tok == "data" || tok == "store") begin
					mode = tok;
				end else if (tok == "run") begin
					runTest(name);
				end else if (mode == "prog") begin
					void'($sscanf(tok, "%h", word));
					u_memory.instrMem[progLen] = word;
					progLen++;
				end else begin
					// Address and value pairs
					void'($sscanf(tok, "%h", word));
					void'($fscanf(fd, "%h", value));
					if (mode == "data") begin
						u_memory.dataMem[word[7:0]] = value;
					end else begin
						expAddrs.push_back(word);
						expValues.push_back(value);
					end
				end
			end
			$fclose(fd);
		end
		if (passCount + failCount == 0) begin
			$display("No test was run from %s", vectorFile);
			failCount++;
		end
		$display("%0d tests run, %0d passed, %0d failed", passCount + failCount, passCount,
			failCount);
		if (failCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== tbMemory.sv ====
// Instruction and data memory model with random wait states and a log of completed stores
module tbMemory (
	input  logic clk,
	input  logic reset,
	input  logic [31:0] instrAddr,
	input  logic instrValid,
	output logic [31:0] instrData,
	output logic instrReady,
	input  logic [31:0] dataAddr,
	input  logic [31:0] writeData,
	input  logic dataWrite,
	input  logic dataValid,
	output logic [31:0] readData,
	output logic dataReady
);

	localparam int depth = 256;
	localparam int maxWait = 3;
	localparam int unsigned seed = 32'h745f_a404;

	logic [31:0] instrMem [depth];
	logic [31:0] dataMem [depth];
	logic [31:0] storeAddrs [$];
	logic [31:0] storeValues [$];

	task automatic clearMemories();
		int i;
		for (i = 0; i < depth; i++) begin
			instrMem[i] = '0;
			// Unwritten data words carry their own index
			dataMem[i] = 32'hd0d0_0000 ^ i;
		end
	endtask

	initial begin
		int instrWait;
		int dataWait;
		bit instrBusy;
		bit dataBusy;
		bit resetSeen;
		instrData = '0;
		instrReady = 1'b0;
		readData = '0;
		dataReady = 1'b0;
		instrWait = 0;
		dataWait = 0;
		instrBusy = 1'b0;
		dataBusy = 1'b0;
		void'($urandom(seed));
		forever begin
			@(posedge clk);
			resetSeen = reset;
			#1;
			if (resetSeen) begin
				instrReady = 1'b0;
				dataReady = 1'b0;
				instrBusy = 1'b0;
				dataBusy = 1'b0;
				storeAddrs.delete();
				storeValues.delete();
			end else begin
				// Ready seen on the last edge means the transfer is done
				if (instrReady)
					instrBusy = 1'b0;
				if (instrValid && !instrBusy) begin
					instrBusy = 1'b1;
					instrWait = $urandom % (maxWait + 1);
				end else if (instrBusy && instrWait > 0) begin
					instrWait--;
				end
				instrReady = instrBusy && instrWait == 0;
				instrData = instrMem[instrAddr[7:0]];

				if (dataReady)
					dataBusy = 1'b0;
				if (dataValid && !dataBusy) begin
					dataBusy = 1'b1;
					dataWait = $urandom % (maxWait + 1);
				end else if (dataBusy && dataWait > 0) begin
					dataWait--;
				end
				dataReady = dataBusy && dataWait == 0;
				// Request holds until the edge, so the store counts now
				if (dataReady && dataWrite) begin
					dataMem[dataAddr[7:0]] = writeData;
					storeAddrs.push_back(dataAddr);
					storeValues.push_back(writeData);
				end
				readData = dataMem[dataAddr[7:0]];
			end
		end
	end

endmodule

// ==== pipelineCpu.sv ====
// Five-stage pipelined CPU top level joining the stages and the hazard unit
module pipelineCpu (
	input  logic clk,
	input  logic reset,
	input  logic [cpuPkg::xlen-1:0] instrData,
	input  logic instrReady,
	input  logic [cpuPkg::xlen-1:0] readData,
	input  logic dataReady,
	output logic [cpuPkg::xlen-1:0] instrAddr,
	output logic instrValid,
	output logic [cpuPkg::xlen-1:0] dataAddr,
	output logic [cpuPkg::xlen-1:0] writeData,
	output logic dataWrite,
	output logic dataValid,
	output logic halt
);
	import cpuPkg::*;

	// Fetch to decode
	logic [xlen-1:0] ifInstr;
	logic [xlen-1:0] ifNextPc;
	logic [regAddrBits-1:0] idRs;
	logic [regAddrBits-1:0] idRt;

	// Decode/execute register
	opcodeT exOpcode;
	aluOpT exAluOp;
	logic [xlen-1:0] exSrcA;
	logic [xlen-1:0] exSrcB;
	logic [xlen-1:0] exImm;
	logic [xlen-1:0] exNextPc;
	logic [xlen-1:0] exTarget;
	logic [regAddrBits-1:0] exRd;
	logic [regAddrBits-1:0] exRs;
	logic [regAddrBits-1:0] exRt;
	logic exWriteEn;

	// Execute/memory register and redirect
	opcodeT memOpcode;
	logic [xlen-1:0] memResult;
	logic [xlen-1:0] memStoreData;
	logic [regAddrBits-1:0] memRd;
	logic memWriteEn;
	logic redirect;
	logic [xlen-1:0] redirectPc;

	// Writeback and pipeline control
	logic wbEn;
	logic [regAddrBits-1:0] wbAddr;
	logic [xlen-1:0] wbData;
	logic memBusy;
	logic stallFront;
	fwdSelT fwdA;
	fwdSelT fwdB;

	// Instruction waits are absorbed inside fetch
	fetchStage u_fetchStage (
		.halted(halt),
		.fetchWait(),
		.*
	);

	decodeStage u_decodeStage (
		.flush(redirect),
		.*
	);

	executeStage u_executeStage (.*);

	memoryStage u_memoryStage (.*);

	hazardUnit u_hazardUnit (.*);

endmodule

// ==== hazardUnit.sv ====
// Hazard unit selecting operand forwarding and detecting the load-use stall
module hazardUnit (
	input  logic [cpuPkg::regAddrBits-1:0] idRs,
	input  logic [cpuPkg::regAddrBits-1:0] idRt,
	input  logic [cpuPkg::regAddrBits-1:0] exRs,
	input  logic [cpuPkg::regAddrBits-1:0] exRt,
	input  logic [cpuPkg::regAddrBits-1:0] exRd,
	input  cpuPkg::opcodeT exOpcode,
	input  logic [cpuPkg::regAddrBits-1:0] memRd,
	input  logic memWriteEn,
	input  logic [cpuPkg::regAddrBits-1:0] wbAddr,
	input  logic wbEn,
	output cpuPkg::fwdSelT fwdA,
	output cpuPkg::fwdSelT fwdB,
	output logic stallFront
);
	import cpuPkg::*;

	// Youngest producer wins
	function automatic fwdSelT selectSource(input logic [regAddrBits-1:0] src,
			input logic [regAddrBits-1:0] mRd, input logic mEn,
			input logic [regAddrBits-1:0] wRd, input logic wEn);
		if (src == '0)
			return fwdNone;
		if (mEn && mRd == src)
			return fwdMem;
		if (wEn && wRd == src)
			return fwdWb;
		return fwdNone;
	endfunction

	assign fwdA = selectSource(exRs, memRd, memWriteEn, wbAddr, wbEn);
	assign fwdB = selectSource(exRt, memRd, memWriteEn, wbAddr, wbEn);

	assign stallFront = exOpcode == opLoad && exRd != '0 && (exRd == idRs || exRd == idRt);

endmodule

// ==== memoryStage.sv ====
// Memory stage issuing data requests, selecting writeback data and tracking halt
module memoryStage (
	input  logic clk,
	input  logic reset,
	input  cpuPkg::opcodeT memOpcode,
	input  logic [cpuPkg::xlen-1:0] memResult,
	input  logic [cpuPkg::xlen-1:0] memStoreData,
	input  logic [cpuPkg::regAddrBits-1:0] memRd,
	input  logic memWriteEn,
	input  logic [cpuPkg::xlen-1:0] readData,
	input  logic dataReady,
	output logic [cpuPkg::xlen-1:0] dataAddr,
	output logic [cpuPkg::xlen-1:0] writeData,
	output logic dataWrite,
	output logic dataValid,
	output logic memBusy,
	output logic wbEn,
	output logic [cpuPkg::regAddrBits-1:0] wbAddr,
	output logic [cpuPkg::xlen-1:0] wbData,
	output logic halt
);
	import cpuPkg::*;

	logic isLoad;
	logic isStore;

	assign isLoad = memOpcode == opLoad;
	assign isStore = memOpcode == opStore;
	assign dataAddr = memResult;
	assign writeData = memStoreData;
	assign dataWrite = isStore;
	// Nothing behind the halt may touch memory
	assign dataValid = (isLoad || isStore) && !halt;
	assign memBusy = dataValid && !dataReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			wbEn <= 1'b0;
			halt <= 1'b0;
		end else if (!memBusy) begin
			wbEn <= memWriteEn && !halt;
			if (memOpcode == opHalt)
				halt <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!memBusy) begin
			wbAddr <= memRd;
			wbData <= isLoad ? readData : memResult;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		memBusy |=> dataValid && $stable(dataAddr) && $stable(dataWrite));

endmodule

// ==== executeStage.sv ====
// Execute stage with operand forwarding, the ALU, branch resolution and the execute/memory register
module executeStage (
	input  logic clk,
	input  logic reset,
	input  logic memBusy,
	input  cpuPkg::opcodeT exOpcode,
	input  cpuPkg::aluOpT exAluOp,
	input  logic [cpuPkg::xlen-1:0] exSrcA,
	input  logic [cpuPkg::xlen-1:0] exSrcB,
	input  logic [cpuPkg::xlen-1:0] exImm,
	input  logic [cpuPkg::xlen-1:0] exNextPc,
	input  logic [cpuPkg::xlen-1:0] exTarget,
	input  logic [cpuPkg::regAddrBits-1:0] exRd,
	input  logic exWriteEn,
	input  cpuPkg::fwdSelT fwdA,
	input  cpuPkg::fwdSelT fwdB,
	input  logic [cpuPkg::xlen-1:0] wbData,
	output logic redirect,
	output logic [cpuPkg::xlen-1:0] redirectPc,
	output cpuPkg::opcodeT memOpcode,
	output logic [cpuPkg::xlen-1:0] memResult,
	output logic [cpuPkg::xlen-1:0] memStoreData,
	output logic [cpuPkg::regAddrBits-1:0] memRd,
	output logic memWriteEn
);
	import cpuPkg::*;

	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;
	logic [xlen-1:0] aluB;
	logic [xlen-1:0] aluResult;
	logic equal;
	logic taken;

	function automatic logic [xlen-1:0] pickOperand(input fwdSelT sel,
			input logic [xlen-1:0] regValue, input logic [xlen-1:0] memValue,
			input logic [xlen-1:0] wbValue);
		case (sel)
			fwdMem: return memValue;
			fwdWb: return wbValue;
			default: return regValue;
		endcase
	endfunction

	assign opA = pickOperand(fwdA, exSrcA, memResult, wbData);
	assign opB = pickOperand(fwdB, exSrcB, memResult, wbData);
	// addi, load and store take the immediate
	assign aluB = (exOpcode == opAlu) ? opB : exImm;

	always_comb begin
		case (exAluOp)
			aluSub: aluResult = opA - aluB;
			aluAnd: aluResult = opA & aluB;
			aluOr: aluResult = opA | aluB;
			aluXor: aluResult = opA ^ aluB;
			aluSll: aluResult = opA << aluB[shiftBits-1:0];
			aluSrl: aluResult = opA >> aluB[shiftBits-1:0];
			aluSlt: aluResult = {{(xlen-1){1'b0}}, $signed(opA) < $signed(aluB)};
			default: aluResult = opA + aluB;
		endcase
	end

	// Static not-taken, so any taken branch redirects
	assign equal = opA == opB;
	assign taken = (exOpcode == opBeq && equal) || (exOpcode == opBne && !equal);
	assign redirect = taken || exOpcode == opJump;
	assign redirectPc = (exOpcode == opJump) ? exTarget : exNextPc + exImm;

	always_ff @(posedge clk) begin
		if (reset) begin
			memOpcode <= opNop;
			memWriteEn <= 1'b0;
		end else if (!memBusy) begin
			memOpcode <= exOpcode;
			memWriteEn <= exWriteEn;
		end
	end

	always_ff @(posedge clk) begin
		if (!memBusy) begin
			memResult <= aluResult;
			memStoreData <= opB;
			memRd <= exRd;
		end
	end

	// A load result is never in memResult, the load-use stall must cover it
	assert property (@(posedge clk) disable iff (reset)
		(fwdA == fwdMem || fwdB == fwdMem) |-> memOpcode != opLoad);

endmodule

// ==== decodeStage.sv ====
// Decode stage with the register file, control decode and the decode/execute register
module decodeStage (
	input  logic clk,
	input  logic reset,
	input  logic [cpuPkg::xlen-1:0] ifInstr,
	input  logic [cpuPkg::xlen-1:0] ifNextPc,
	input  logic stallFront,
	input  logic memBusy,
	input  logic flush,
	input  logic wbEn,
	input  logic [cpuPkg::regAddrBits-1:0] wbAddr,
	input  logic [cpuPkg::xlen-1:0] wbData,
	output logic [cpuPkg::regAddrBits-1:0] idRs,
	output logic [cpuPkg::regAddrBits-1:0] idRt,
	output cpuPkg::opcodeT exOpcode,
	output cpuPkg::aluOpT exAluOp,
	output logic [cpuPkg::xlen-1:0] exSrcA,
	output logic [cpuPkg::xlen-1:0] exSrcB,
	output logic [cpuPkg::xlen-1:0] exImm,
	output logic [cpuPkg::xlen-1:0] exNextPc,
	output logic [cpuPkg::xlen-1:0] exTarget,
	output logic [cpuPkg::regAddrBits-1:0] exRd,
	output logic [cpuPkg::regAddrBits-1:0] exRs,
	output logic [cpuPkg::regAddrBits-1:0] exRt,
	output logic exWriteEn
);
	import cpuPkg::*;

	logic [xlen-1:0] regFile [2**regAddrBits];
	opcodeT opcode;
	aluOpT aluOp;
	logic [regAddrBits-1:0] rdField;
	logic readsRs;
	logic readsRt;
	logic readsRd;
	logic writesRd;
	logic [xlen-1:0] srcA;
	logic [xlen-1:0] srcB;

	assign opcode = opcodeT'(ifInstr[opcodeLsb +: opcodeBits]);
	assign rdField = ifInstr[rdLsb +: regAddrBits];

	always_comb begin
		readsRs = 1'b1;
		readsRt = 1'b0;
		readsRd = 1'b0;
		writesRd = 1'b0;
		aluOp = aluAdd;
		case (opcode)
			opAlu: begin
				readsRt = 1'b1;
				writesRd = 1'b1;
				aluOp = aluOpT'(ifInstr[aluOpBits-1:0]);
			end
			opAddi, opLoad: writesRd = 1'b1;
			// Stores and branches read rd as their second operand
			opStore, opBeq, opBne: readsRd = 1'b1;
			default: readsRs = 1'b0;
		endcase
	end

	assign idRs = readsRs ? ifInstr[rsLsb +: regAddrBits] : '0;
	assign idRt = readsRd ? rdField : (readsRt ? ifInstr[rtLsb +: regAddrBits] : '0);

	// Write-then-read bypass from writeback
	assign srcA = (idRs == '0) ? '0 : (wbEn && wbAddr == idRs) ? wbData : regFile[idRs];
	assign srcB = (idRt == '0) ? '0 : (wbEn && wbAddr == idRt) ? wbData : regFile[idRt];

	always_ff @(posedge clk) begin
		if (wbEn && wbAddr != '0)
			regFile[wbAddr] <= wbData;
	end

	always_ff @(posedge clk) begin
		if (reset || (!memBusy && (flush || stallFront))) begin
			exOpcode <= opNop;
			exWriteEn <= 1'b0;
			exRd <= '0;
			exRs <= '0;
			exRt <= '0;
		end else if (!memBusy) begin
			exOpcode <= opcode;
			exWriteEn <= writesRd && rdField != '0;
			exRd <= rdField;
			exRs <= idRs;
			exRt <= idRt;
		end
	end

	always_ff @(posedge clk) begin
		if (!memBusy) begin
			exAluOp <= aluOp;
			exSrcA <= srcA;
			exSrcB <= srcB;
			exImm <= {{(xlen-immBits){ifInstr[immBits-1]}}, ifInstr[immBits-1:0]};
			exNextPc <= ifNextPc;
			exTarget <= {{(xlen-targetBits){1'b0}}, ifInstr[targetBits-1:0]};
		end
	end

	// No writeback from the pipeline ever targets r0
	assert property (@(posedge clk) disable iff (reset)
		wbEn |-> wbAddr != '0);

endmodule

// ==== fetchStage.sv ====
// Fetch stage holding the PC, issuing instruction requests and loading the fetch/decode register
module fetchStage (
	input  logic clk,
	input  logic reset,
	input  logic stallFront,
	input  logic memBusy,
	input  logic redirect,
	input  logic [cpuPkg::xlen-1:0] redirectPc,
	input  logic halted,
	input  logic [cpuPkg::xlen-1:0] instrData,
	input  logic instrReady,
	output logic [cpuPkg::xlen-1:0] instrAddr,
	output logic instrValid,
	output logic fetchWait,
	output logic [cpuPkg::xlen-1:0] ifInstr,
	output logic [cpuPkg::xlen-1:0] ifNextPc
);
	import cpuPkg::*;

	logic [xlen-1:0] pc;
	logic [xlen-1:0] pendPc;
	logic [xlen-1:0] heldInstr;
	logic [xlen-1:0] heldNextPc;
	logic started;
	logic reqActive;
	logic pendRedirect;
	logic heldValid;
	logic accept;
	logic take;
	logic frontMove;

	// An open request is kept alive even after halt
	assign instrAddr = pc;
	assign instrValid = reqActive || (started && !halted && !heldValid);
	assign fetchWait = instrValid && !instrReady;
	assign accept = instrValid && instrReady;
	assign take = redirect && !memBusy;
	assign frontMove = !memBusy && !stallFront;

	always_ff @(posedge clk) begin
		if (reset) begin
			started <= 1'b0;
			reqActive <= 1'b0;
			pendRedirect <= 1'b0;
			pc <= resetPc;
		end else begin
			started <= 1'b1;
			reqActive <= fetchWait;
			// Redirect during a wait is applied once the word arrives
			if (take && !fetchWait)
				pc <= redirectPc;
			else if (accept)
				pc <= pendRedirect ? pendPc : pc + 1'b1;
			if (take && fetchWait)
				pendRedirect <= 1'b1;
			else if (take || accept)
				pendRedirect <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take && fetchWait)
			pendPc <= redirectPc;
		if (accept) begin
			heldInstr <= instrData;
			heldNextPc <= pc + 1'b1;
		end
	end

	// Word accepted while the front end is stalled
	always_ff @(posedge clk) begin
		if (reset || take || frontMove)
			heldValid <= 1'b0;
		else if (accept && !pendRedirect)
			heldValid <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset || take) begin
			ifInstr <= '0;
		end else if (frontMove) begin
			if (heldValid) begin
				ifInstr <= heldInstr;
				ifNextPc <= heldNextPc;
			end else if (accept && !pendRedirect) begin
				ifInstr <= instrData;
				ifNextPc <= pc + 1'b1;
			end else begin
				ifInstr <= '0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		fetchWait |=> instrValid && $stable(instrAddr));

endmodule

// ==== cpuPkg.sv ====
// CPU package with instruction layout, widths and the opcode, ALU and forwarding encodings
package cpuPkg;

	localparam int xlen = 32;
	localparam int regAddrBits = 5;
	localparam int immBits = 16;
	localparam int targetBits = 26;
	localparam int opcodeBits = 6;
	localparam int aluOpBits = 4;
	localparam int shiftBits = 5;

	// Instruction field positions
	localparam int opcodeLsb = 26;
	localparam int rdLsb = 21;
	localparam int rsLsb = 16;
	localparam int rtLsb = 11;

	localparam logic [xlen-1:0] resetPc = '0;

	// Opcode zero doubles as the pipeline bubble
	typedef enum logic [opcodeBits-1:0] {
		opNop = 6'd0,
		opAlu = 6'd1,
		opAddi = 6'd2,
		opLoad = 6'd3,
		opStore = 6'd4,
		opBeq = 6'd5,
		opBne = 6'd6,
		opJump = 6'd7,
		opHalt = 6'd8
	} opcodeT;

	// Function code for opAlu
	typedef enum logic [aluOpBits-1:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr = 4'd3,
		aluXor = 4'd4,
		aluSll = 4'd5,
		aluSrl = 4'd6,
		aluSlt = 4'd7
	} aluOpT;

	typedef enum logic [1:0] {
		fwdNone = 2'd0,
		fwdMem = 2'd1,
		fwdWb = 2'd2
	} fwdSelT;

endpackage
